// ==== rtl/lts_correlator.sv ====
`default_nettype none

`include "sync_long_defines.svh"

module lts_correlator (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        enable_i,
    input  wire                        valid_i,
    output logic                       ready_o,
    input  wire ofdm_sample_pkg::sample_t sample_i,
    output logic                       metric_valid_o,
    output ofdm_sample_pkg::metric_t   metric_o
);
    import ofdm_sample_pkg::*;

    localparam int PASSES = `CORR_LEN / `CORR_LANES;

    sample_t    window [`CORR_LEN];   // [CORR_LEN-1] holds the newest sample
    logic       busy_q;
    logic [1:0] pass_q;
    logic       accept;

    sample_t    x_lane [`CORR_LANES];
    sample_t    t_lane [`CORR_LANES];

    logic       prod_vld_q;
    logic [1:0] prod_pass_q;
    corr_t      prod_i_q [`CORR_LANES];
    corr_t      prod_q_q [`CORR_LANES];
    corr_t      lane_sum_i;
    corr_t      lane_sum_q;

    corr_t      acc_i_q;
    corr_t      acc_q_q;
    logic       acc_done_q;
    corr_t      abs_i_q;
    corr_t      abs_q_q;
    logic       abs_vld_q;
    corr_t      max_q;
    corr_t      min_q;
    logic       mm_vld_q;
    logic       metric_vld_q;

    assign ready_o        = enable_i && !busy_q;  // multipliers shared over four passes
    assign accept         = valid_i && ready_o;
    assign metric_valid_o = enable_i && metric_vld_q;

    // window slice and reference slice for the current pass
    always_comb begin
        for (int l = 0; l < `CORR_LANES; l++) begin
            x_lane[l] = window[pass_q * `CORR_LANES + l];
            t_lane[l] = LTS_TAPS[pass_q * `CORR_LANES + l];
        end
    end

    always_comb begin
        lane_sum_i = '0;
        lane_sum_q = '0;
        for (int l = 0; l < `CORR_LANES; l++) begin
            lane_sum_i = lane_sum_i + prod_i_q[l];
            lane_sum_q = lane_sum_q + prod_q_q[l];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < `CORR_LEN; k++) begin
                window[k] <= '0;  // samples before the search count as zero
            end
            busy_q       <= 1'b0;
            pass_q       <= '0;
            prod_vld_q   <= 1'b0;
            acc_done_q   <= 1'b0;
            abs_vld_q    <= 1'b0;
            mm_vld_q     <= 1'b0;
            metric_vld_q <= 1'b0;
        end else if (enable_i) begin
            if (accept) begin
                for (int k = 0; k < `CORR_LEN - 1; k++) begin
                    window[k] <= window[k+1];
                end
                window[`CORR_LEN-1] <= sample_i;
                busy_q <= 1'b1;
            end else if (busy_q && pass_q == PASSES - 1) begin
                busy_q <= 1'b0;
            end
            if (busy_q) begin
                pass_q <= pass_q + 1'b1;  // wraps back to 0 after the last pass
            end
            prod_vld_q   <= busy_q;
            acc_done_q   <= prod_vld_q && prod_pass_q == PASSES - 1;
            abs_vld_q    <= acc_done_q;
            mm_vld_q     <= abs_vld_q;
            metric_vld_q <= mm_vld_q;
        end
    end

    always_ff @(posedge clock) begin
        if (enable_i) begin
            // x * conj(tap)
            for (int l = 0; l < `CORR_LANES; l++) begin
                prod_i_q[l] <= x_lane[l].i * t_lane[l].i + x_lane[l].q * t_lane[l].q;
                prod_q_q[l] <= x_lane[l].q * t_lane[l].i - x_lane[l].i * t_lane[l].q;
            end
            prod_pass_q <= pass_q;

            if (prod_vld_q) begin
                acc_i_q <= (prod_pass_q == '0 ? corr_t'(0) : acc_i_q) + lane_sum_i;
                acc_q_q <= (prod_pass_q == '0 ? corr_t'(0) : acc_q_q) + lane_sum_q;
            end

            abs_i_q <= acc_i_q[31] ? -acc_i_q : acc_i_q;
            abs_q_q <= acc_q_q[31] ? -acc_q_q : acc_q_q;

            if (abs_i_q > abs_q_q) begin
                max_q <= abs_i_q;
                min_q <= abs_q_q;
            end else begin
                max_q <= abs_q_q;
                min_q <= abs_i_q;
            end

            // max + min/4 approximation of the magnitude
            metric_o <= metric_t'(max_q + (min_q >>> 2));
        end
    end

    // a pass sequence is never interrupted by a new beat
    a_no_accept_in_pass: assert property (@(posedge clock) disable iff (reset)
        accept |=> !accept [*PASSES]);

endmodule

`default_nettype wire

// ==== rtl/lts_sync_ctrl.sv ====
`default_nettype none

`include "sync_long_defines.svh"

module lts_sync_ctrl (
    input  wire                              clock,
    input  wire                              reset,
    input  wire                              enable_i,
    input  wire                              in_fire_i,
    input  wire                              metric_valid_i,
    input  wire ofdm_sample_pkg::metric_t    metric_i,
    input  wire signed [15:0]                phase_offset_i,
    input  wire                              short_gi_i,
    input  wire [3:0]                        win_shift_i,
    input  wire [`BUF_ADDR_W:0]              fill_i,
    output logic                             rd_en_o,
    output ofdm_sample_pkg::buf_addr_t       rd_addr_o,
    input  wire ofdm_sample_pkg::sample_t    rd_sample_i,
    output ofdm_sample_pkg::buf_addr_t       consume_o,
    output sync_long_ctrl_pkg::ctrl_state_e  state_o,
    output logic                             detected_o,
    output logic                             out_valid_o,
    input  wire                              out_ready_i,
    output ofdm_sample_pkg::sym_beat_t       out_beat_o
);
    import ofdm_sample_pkg::*;
    import sync_long_ctrl_pkg::*;

    ctrl_state_e state_q;
    buf_addr_t   cnt_q;      // skipped samples, then metrics seen
    metric_t     max_q;
    buf_addr_t   peak_q;
    logic        detected_q;

    buf_addr_t   rd_addr_q;
    logic [5:0]  sym_off_q;
    logic [15:0] sym_idx_q;
    logic        in_sym_q;   // committed to the current symbol
    logic [4:0]  gi_left_q;  // guard samples still to step over
    phase_t      phase_q;    // phase at rd_addr_q
    phase_t      phase_sum;
    phase_t      phase_nxt;

    logic        out_valid_q;
    phase_t      out_phase_q;
    logic [15:0] out_idx_q;
    logic        out_last_q;

    logic [4:0]  gi_len;
    logic        new_peak;
    logic        detect;
    logic        go;
    logic        guard_step;
    logic        rd_go;
    logic        last;
    buf_addr_t   peak_idx;
    buf_addr_t   s0;

    assign gi_len   = short_gi_i ? 5'(`GI_SHORT) : 5'(`GI_LONG);
    assign new_peak = metric_valid_i && metric_i > max_q;  // strict, keeps the first max
    assign peak_idx = new_peak ? cnt_q : peak_q;
    assign s0       = peak_idx - buf_addr_t'(`CORR_LEN - 1) - buf_addr_t'(win_shift_i);
    assign detect   = enable_i && state_q == ST_SEARCH && metric_valid_i
                      && cnt_q == buf_addr_t'(`SEARCH_LEN - 1);

    // a new symbol waits until its samples and the guard before it are buffered
    assign go         = enable_i && state_q == ST_STREAM
                        && (in_sym_q || fill_i >= 9'(`SYM_LEN) + 9'(gi_left_q));
    assign guard_step = go && gi_left_q != '0;
    assign rd_go      = go && gi_left_q == '0 && (!out_valid_q || out_ready_i);
    assign last       = sym_off_q == 6'(`SYM_LEN - 1);

    assign rd_en_o     = rd_go;
    assign rd_addr_o   = rd_addr_q;
    assign consume_o   = detect ? s0 : buf_addr_t'(guard_step || rd_go);
    assign state_o     = state_q;
    assign detected_o  = enable_i && detected_q;
    assign out_valid_o = enable_i && out_valid_q;
    assign out_beat_o  = '{sample: rd_sample_i, phase: out_phase_q,
                           symbol_index: out_idx_q, last: out_last_q};

    // one index step with a single wrap into -pi..pi
    always_comb begin
        phase_sum = phase_q + phase_t'(phase_offset_i);
        if (phase_sum > PI) begin
            phase_nxt = phase_sum - DOUBLE_PI;
        end else if (phase_sum < -PI) begin
            phase_nxt = phase_sum + DOUBLE_PI;
        end else begin
            phase_nxt = phase_sum;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q     <= ST_SKIP;
            cnt_q       <= '0;
            max_q       <= '0;
            peak_q      <= '0;
            detected_q  <= 1'b0;
            rd_addr_q   <= '0;
            sym_off_q   <= '0;
            sym_idx_q   <= '0;
            in_sym_q    <= 1'b0;
            gi_left_q   <= '0;
            phase_q     <= '0;
            out_valid_q <= 1'b0;
        end else if (enable_i) begin
            detected_q <= detect;
            case (state_q)
                ST_SKIP: begin
                    if (in_fire_i) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == buf_addr_t'(`STS_TAIL - 1)) begin
                            state_q <= ST_SEARCH;
                            cnt_q   <= '0;  // metric index restarts at buffer address 0
                        end
                    end
                end
                ST_SEARCH: begin
                    if (metric_valid_i) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (new_peak) begin
                            max_q  <= metric_i;
                            peak_q <= cnt_q;
                        end
                    end
                    if (detect) begin
                        state_q   <= ST_STREAM;
                        rd_addr_q <= s0;
                        phase_q   <= '0;
                    end
                end
                default: begin
                    if (out_valid_q && out_ready_i) begin
                        out_valid_q <= 1'b0;
                    end
                    if (guard_step || rd_go) begin
                        rd_addr_q <= rd_addr_q + 1'b1;
                        phase_q   <= phase_nxt;
                        in_sym_q  <= 1'b1;
                    end
                    if (guard_step) begin
                        gi_left_q <= gi_left_q - 1'b1;
                    end
                    if (rd_go) begin
                        out_valid_q <= 1'b1;
                        out_phase_q <= phase_q;
                        out_idx_q   <= sym_idx_q;
                        out_last_q  <= last;
                        sym_off_q   <= sym_off_q + 1'b1;
                        if (last) begin
                            in_sym_q  <= 1'b0;
                            sym_idx_q <= sym_idx_q + 1'b1;
                            // the two training symbols run back to back
                            gi_left_q <= (sym_idx_q != '0) ? gi_len : 5'd0;
                        end
                    end
                end
            endcase
        end
    end

    // stalled beat holds across controller and buffer read register
    a_out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid_o && !out_ready_i |=> !enable_i || (out_valid_o && $stable(out_beat_o)));

endmodule

`default_nettype wire

// ==== rtl/ofdm_sample_pkg.sv ====
`default_nettype none

`include "sync_long_defines.svh"

package ofdm_sample_pkg;

    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] i;
        logic signed [`SAMPLE_W-1:0] q;
    } sample_t;

    typedef logic signed [31:0]      corr_t;
    typedef logic [31:0]             metric_t;
    typedef logic [`BUF_ADDR_W-1:0]  buf_addr_t;

    // one output beat
    typedef struct packed {
        sample_t                    sample;
        sync_long_ctrl_pkg::phase_t phase;
        logic [15:0]                symbol_index;
        logic                       last;   // 64th sample of the symbol
    } sym_beat_t;

    // first 32 samples of the long training symbol, conjugated in the multiply
    localparam sample_t LTS_TAPS [`CORR_LEN] = '{
        '{16'sd156, 16'sd0},     '{-16'sd5, -16'sd120},   '{16'sd40, -16'sd111},
        '{16'sd97, 16'sd83},     '{16'sd21, 16'sd28},     '{16'sd60, -16'sd88},
        '{-16'sd115, -16'sd55},  '{-16'sd38, -16'sd106},  '{16'sd98, -16'sd26},
        '{16'sd53, 16'sd4},      '{16'sd1, -16'sd115},    '{-16'sd137, -16'sd47},
        '{16'sd24, -16'sd59},    '{16'sd59, -16'sd15},    '{-16'sd22, 16'sd161},
        '{16'sd119, -16'sd4},    '{16'sd62, -16'sd62},    '{16'sd37, 16'sd98},
        '{-16'sd57, 16'sd39},    '{-16'sd131, 16'sd65},   '{16'sd82, 16'sd92},
        '{16'sd70, 16'sd14},     '{-16'sd60, 16'sd81},    '{-16'sd56, -16'sd22},
        '{-16'sd35, -16'sd151},  '{-16'sd122, -16'sd17},  '{-16'sd127, -16'sd21},
        '{16'sd75, -16'sd74},    '{-16'sd3, 16'sd54},     '{-16'sd92, 16'sd115},
        '{16'sd92, 16'sd106},    '{16'sd12, 16'sd98}
    };

endpackage

`default_nettype wire

// ==== rtl/sample_buffer.sv ====
`default_nettype none

`include "sync_long_defines.svh"

module sample_buffer (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            wr_en_i,
    input  wire ofdm_sample_pkg::sample_t  wr_sample_i,
    input  wire                            rd_en_i,
    input  wire ofdm_sample_pkg::buf_addr_t rd_addr_i,
    output ofdm_sample_pkg::sample_t       rd_sample_o,
    input  wire ofdm_sample_pkg::buf_addr_t consume_i,
    output logic [`BUF_ADDR_W:0]           fill_o
);
    import ofdm_sample_pkg::*;

    sample_t   mem [2**`BUF_ADDR_W];
    buf_addr_t wr_ptr_q;

    always_ff @(posedge clock) begin
        if (wr_en_i) begin
            mem[wr_ptr_q] <= wr_sample_i;
        end
        // read data holds until the next strobe
        if (rd_en_i) begin
            rd_sample_o <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr_q <= '0;
            fill_o   <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            fill_o <= fill_o + (`BUF_ADDR_W+1)'(wr_en_i) - (`BUF_ADDR_W+1)'(consume_i);
        end
    end

    // the input side must stop before the writer laps the reader
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        wr_en_i |-> fill_o < (`BUF_ADDR_W+1)'(2**`BUF_ADDR_W));

endmodule

`default_nettype wire

// ==== rtl/sync_long.sv ====
`default_nettype none

`include "sync_long_defines.svh"

module sync_long (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            enable_i,
    input  wire                            in_valid_i,
    output logic                           in_ready_o,
    input  wire ofdm_sample_pkg::sample_t  in_sample_i,
    input  wire signed [15:0]              phase_offset_i,
    input  wire                            short_gi_i,
    input  wire [3:0]                      win_shift_i,
    output logic                           out_valid_o,
    input  wire                            out_ready_i,
    output ofdm_sample_pkg::sym_beat_t     out_beat_o,
    output logic                           metric_valid_o,
    output ofdm_sample_pkg::metric_t       metric_o,
    output logic                           detected_o
);
    import ofdm_sample_pkg::*;
    import sync_long_ctrl_pkg::*;

    ctrl_state_e          state;
    logic                 corr_valid;
    logic                 corr_ready;
    logic                 in_fire;
    logic                 wr_en;
    logic                 rd_en;
    buf_addr_t            rd_addr;
    buf_addr_t            consume;
    sample_t              rd_sample;
    logic [`BUF_ADDR_W:0] fill;

    always_comb begin
        case (state)
            ST_SKIP:   in_ready_o = enable_i;   // tail beats are dropped
            ST_SEARCH: in_ready_o = corr_ready;
            default:   in_ready_o = enable_i && fill < (`BUF_ADDR_W+1)'(`BUF_HIGH_WATER);
        endcase
    end

    assign in_fire    = in_valid_i && in_ready_o;
    assign wr_en      = in_fire && state != ST_SKIP;
    assign corr_valid = in_valid_i && state == ST_SEARCH;

    lts_correlator i_correlator (
        .clock          (clock),
        .reset          (reset),
        .enable_i       (enable_i),
        .valid_i        (corr_valid),
        .ready_o        (corr_ready),
        .sample_i       (in_sample_i),
        .metric_valid_o (metric_valid_o),
        .metric_o       (metric_o)
    );

    sample_buffer i_buffer (
        .clock       (clock),
        .reset       (reset),
        .wr_en_i     (wr_en),
        .wr_sample_i (in_sample_i),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_sample_o (rd_sample),
        .consume_i   (consume),
        .fill_o      (fill)
    );

    lts_sync_ctrl i_ctrl (
        .clock          (clock),
        .reset          (reset),
        .enable_i       (enable_i),
        .in_fire_i      (in_fire),
        .metric_valid_i (metric_valid_o),
        .metric_i       (metric_o),
        .phase_offset_i (phase_offset_i),
        .short_gi_i     (short_gi_i),
        .win_shift_i    (win_shift_i),
        .fill_i         (fill),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_sample_i    (rd_sample),
        .consume_o      (consume),
        .state_o        (state),
        .detected_o     (detected_o),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_beat_o     (out_beat_o)
    );

endmodule

`default_nettype wire

// ==== rtl/sync_long_ctrl_pkg.sv ====
`default_nettype none

`include "sync_long_defines.svh"

package sync_long_ctrl_pkg;

    // scaled phase, pi is PHASE_PI
    typedef logic signed [31:0] phase_t;

    typedef enum logic [1:0] {
        ST_SKIP,    // dropping the short preamble tail
        ST_SEARCH,  // correlating and tracking the peak
        ST_STREAM   // reading out symbols
    } ctrl_state_e;

    localparam phase_t PI        = `PHASE_PI;
    localparam phase_t DOUBLE_PI = 2 * `PHASE_PI;

endpackage

`default_nettype wire

// ==== rtl/sync_long_defines.svh ====
`ifndef SYNC_LONG_DEFINES_SVH
`define SYNC_LONG_DEFINES_SVH

// sample component width
`define SAMPLE_W 16

// sample buffer, 256 entries
`define BUF_ADDR_W 8
`define BUF_HIGH_WATER 240

// cross-correlation against the long training symbol
`define CORR_LEN 32
`define CORR_LANES 8

// short preamble tail and peak search window
`define STS_TAIL 32
`define SEARCH_LEN 88

// symbol framing
`define SYM_LEN 64
`define GI_LONG 16
`define GI_SHORT 8

// pi scaled by 512
`define PHASE_PI 1608

`endif

// ==== sync_long.f ====
+incdir+rtl
rtl/sync_long_ctrl_pkg.sv
rtl/ofdm_sample_pkg.sv
rtl/lts_correlator.sv
rtl/sample_buffer.sv
rtl/lts_sync_ctrl.sv
rtl/sync_long.sv
tb/sync_long_tb.sv

// ==== tb/sync_long_tb.sv ====
`default_nettype none

`include "sync_long_defines.svh"

module sync_long_tb;
    import ofdm_sample_pkg::*;
    import sync_long_ctrl_pkg::*;

    localparam int N_SKIP     = `STS_TAIL;
    localparam int N_POST     = 600;            // samples written to the buffer
    localparam int N_IN       = N_SKIP + N_POST;
    localparam int WAIT_LIMIT = 20000;

    logic               clock = 1'b0;
    logic               reset;
    logic               enable_i;
    logic               in_valid_i;
    logic               in_ready_o;
    sample_t            in_sample_i;
    logic signed [15:0] phase_offset_i;
    logic               short_gi_i;
    logic [3:0]         win_shift_i;
    logic               out_valid_o;
    logic               out_ready_i;
    sym_beat_t          out_beat_o;
    logic               metric_valid_o;
    metric_t            metric_o;
    logic               detected_o;

    integer    seed = 32'h52;
    string     test_name;
    sample_t   stim [N_IN];
    int        stim_idx;
    logic      in_fire_q;
    sym_beat_t exp_q [$];
    int        metric_cnt;
    int        detect_cnt;
    int        beat_cnt;
    int        metric_errors;
    int        beat_errors;
    int        other_errors;

    sync_long i_dut (
        .clock          (clock),
        .reset          (reset),
        .enable_i       (enable_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_sample_i    (in_sample_i),
        .phase_offset_i (phase_offset_i),
        .short_gi_i     (short_gi_i),
        .win_shift_i    (win_shift_i),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_beat_o     (out_beat_o),
        .metric_valid_o (metric_valid_o),
        .metric_o       (metric_o),
        .detected_o     (detected_o)
    );

    always #50 clock = ~clock;

    always @(posedge clock) in_fire_q <= in_valid_i && in_ready_o;  // input transfer seen

    function automatic logic signed [15:0] random_component(input int amp);
        return 16'($random(seed) % amp);
    endfunction

    // |sum x[n-31+k] * conj(tap k)| as max + min/4
    function automatic metric_t ref_metric(input int n);
        longint  acc_i;
        longint  acc_q;
        longint  mag_i;
        longint  mag_q;
        sample_t x;
        acc_i = 0;
        acc_q = 0;
        for (int k = 0; k < `CORR_LEN; k++) begin
            if (n - (`CORR_LEN - 1) + k >= 0) begin
                x = stim[N_SKIP + n - (`CORR_LEN - 1) + k];
                acc_i += longint'(x.i) * LTS_TAPS[k].i + longint'(x.q) * LTS_TAPS[k].q;
                acc_q += longint'(x.q) * LTS_TAPS[k].i - longint'(x.i) * LTS_TAPS[k].q;
            end
        end
        mag_i = (acc_i < 0) ? -acc_i : acc_i;
        mag_q = (acc_q < 0) ? -acc_q : acc_q;
        if (mag_i > mag_q) begin
            return metric_t'(mag_i + (mag_q >>> 2));
        end
        return metric_t'(mag_q + (mag_i >>> 2));
    endfunction

    function automatic int ref_peak();
        metric_t best;
        int      p;
        best = '0;
        p    = 0;
        for (int n = 0; n < `SEARCH_LEN; n++) begin
            if (ref_metric(n) > best) begin  // first maximum wins
                best = ref_metric(n);
                p    = n;
            end
        end
        return p;
    endfunction

    function automatic int sym_start(input int k, input int s0, input logic sgi);
        int gi;
        gi = sgi ? `GI_SHORT : `GI_LONG;
        if (k == 0) begin
            return s0;
        end
        return s0 + `SYM_LEN * k + (k - 1) * gi;  // no guard between symbols 0 and 1
    endfunction

    function automatic phase_t wrapped_phase(input int a, input int s0, input int off);
        phase_t ph;
        ph = 0;
        for (int i = s0; i < a; i++) begin
            ph += off;
            if (ph > `PHASE_PI) ph -= 2 * `PHASE_PI;
            else if (ph < -`PHASE_PI) ph += 2 * `PHASE_PI;
        end
        return ph;
    endfunction

    // sts tail, quiet stretch, two lts copies, then data
    task automatic build_stimulus();
        for (int n = 0; n < N_IN; n++) begin
            if (n < N_SKIP) stim[n] = '{random_component(4096), random_component(4096)};
            else if (n < N_SKIP + 40) stim[n] = '{random_component(16), random_component(16)};
            else if (n < N_SKIP + 104) stim[n] = LTS_TAPS[(n - N_SKIP - 40) % `CORR_LEN];
            else stim[n] = '{random_component(2048), random_component(2048)};
        end
    endtask

    task automatic build_expected(input int s0, input logic sgi, input int off);
        sym_beat_t beat;
        int        k;
        int        a;
        exp_q.delete();
        k = 0;
        while (sym_start(k, s0, sgi) + `SYM_LEN <= N_POST) begin
            for (int j = 0; j < `SYM_LEN; j++) begin
                a                 = sym_start(k, s0, sgi) + j;
                beat.sample       = stim[N_SKIP + a];
                beat.phase        = wrapped_phase(a, s0, off);
                beat.symbol_index = 16'(k);
                beat.last         = (j == `SYM_LEN - 1);
                exp_q.push_back(beat);
            end
            k++;
        end
    endtask

    task automatic drive_cycle(input bit rnd_ready);
        @(negedge clock);
        if (in_fire_q) stim_idx++;
        in_valid_i  = (stim_idx < N_IN);
        in_sample_i = (stim_idx < N_IN) ? stim[stim_idx] : '0;
        out_ready_i = rnd_ready ? 1'($random(seed)) : 1'b1;
    endtask

    task automatic run_test(input string name, input logic [3:0] ws, input logic sgi,
                            input int off, input bit rnd_ready);
        int timer;
        test_name      = name;
        win_shift_i    = ws;
        short_gi_i     = sgi;
        phase_offset_i = 16'(off);
        build_stimulus();
        build_expected(ref_peak() - (`CORR_LEN - 1) - int'(ws), sgi, off);
        metric_cnt = 0;
        detect_cnt = 0;
        beat_cnt   = 0;
        stim_idx   = 0;
        reset       = 1'b1;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!out_valid_o && !metric_valid_o && !detected_o && in_ready_o) else begin
            other_errors++;
            $display("%s: outputs not in their idle state after reset", name);
        end
        timer = 0;
        while (detect_cnt == 0 && timer < WAIT_LIMIT) begin
            drive_cycle(rnd_ready);
            timer++;
        end
        assert (detect_cnt != 0) else begin
            other_errors++;
            $display("%s: timed out waiting for the peak detection", name);
        end
        timer = 0;
        while ((stim_idx < N_IN || exp_q.size() != 0) && timer < WAIT_LIMIT) begin
            drive_cycle(rnd_ready);
            timer++;
        end
        assert (exp_q.size() == 0 && stim_idx == N_IN) else begin
            other_errors++;
            $display("%s: timed out with %0d beats missing", name, exp_q.size());
        end
        repeat (40) drive_cycle(rnd_ready);  // catches surplus beats
        assert (detect_cnt == 1) else begin
            other_errors++;
            $display("Error %s detect pulses: expected 1, actual %0d", name, detect_cnt);
        end
    endtask

    always @(posedge clock) begin
        sym_beat_t exp_beat;
        if (!reset) begin
            if (detected_o) begin
                detect_cnt++;
                assert (metric_cnt == `SEARCH_LEN) else begin
                    other_errors++;
                    $display("Error %s metrics before detect: expected %0d, actual %0d",
                             test_name, `SEARCH_LEN, metric_cnt);
                end
            end
            if (metric_valid_o) begin
                assert (metric_o == ref_metric(metric_cnt)) else begin
                    metric_errors++;
                    $display("Error %s metric %0d: expected %0d, actual %0d", test_name,
                             metric_cnt, ref_metric(metric_cnt), metric_o);
                end
                metric_cnt++;
            end
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() != 0) else begin
                    other_errors++;
                    $display("%s: output beat arrived when none was expected", test_name);
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    assert (out_beat_o == exp_beat) else begin
                        beat_errors++;
                        $display("Error %s beat %0d: expected %h, actual %h", test_name,
                                 beat_cnt, exp_beat, out_beat_o);
                    end
                    beat_cnt++;
                end
            end
        end
    end

    initial begin
        reset          = 1'b1;
        enable_i       = 1'b1;
        in_valid_i     = 1'b0;
        in_sample_i    = '0;
        phase_offset_i = '0;
        short_gi_i     = 1'b0;
        win_shift_i    = '0;
        out_ready_i    = 1'b0;
        metric_errors  = 0;
        beat_errors    = 0;
        other_errors   = 0;
        run_test("long_gi_pos_phase", 4'd0, 1'b0, 300, 1'b0);
        run_test("short_gi_neg_phase", 4'd5, 1'b1, -517, 1'b1);
        run_test("long_gi_backpressure", 4'd9, 1'b0, -1200, 1'b1);
        $display("metric errors: %0d, beat errors: %0d, other errors: %0d",
                 metric_errors, beat_errors, other_errors);
        if (metric_errors + beat_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
